/* tb/noc_stim.txt */
// cmd 1: cmd_src_vc_dest_id_len_data, a packet, body flit i carries data plus i
// cmd 2: cmd_node_0_0_00_00_start(4)cycles(4), endpoint hold, cmd 0 ends the list
1_0_0_0_01_01_00000000
1_0_0_1_02_03_00000100
1_0_1_2_03_04_00000200
1_0_0_3_04_05_00000300
1_1_0_0_05_02_00001000
1_1_1_1_06_01_00000000
1_1_0_2_07_04_00001100
1_1_1_3_08_06_00001200
1_2_1_0_09_03_00002000
1_2_0_1_0a_02_00002100
1_2_0_2_0b_01_00000000
1_2_0_3_0c_06_00002200
1_3_0_0_0d_04_00003000
1_3_1_1_0e_03_00003100
1_3_1_2_0f_02_00003200
1_3_0_3_10_01_00000000
1_0_1_3_11_05_00000400
1_1_0_3_12_04_00001300
2_3_0_0_00_00_00100030
2_0_0_0_00_00_00080014
0_0_0_0_00_00_00000000

/* files.f */
common/noc_pkg.sv
switch/vc_buffer.sv
switch/route_unit.sv
switch/switch_allocator.sv
switch/switch.sv
hw/switch_wrapper.sv
tb/switch_wrapper_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := switch_wrapper_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/switch_wrapper_tb.sv */
`timescale 1ns/1ps

module switch_wrapper_tb import noc_pkg::*; ();
    localparam int BUFFER_SIZE = 8;
    localparam int MAX_CMDS    = 64;

    logic  clk;
    logic  arst_n;
    flit_t in_flit          [4];
    logic  data_ready_in    [4];
    logic  packet_sent      [4];
    flit_t out              [4];
    logic  data_ready_out   [4];
    logic  buffer_available [8];

    logic [63:0] stim_mem [MAX_CMDS];
    flit_t       inj_q    [4][$];
    // Expected flits keyed by destination, source and vc
    flit_t       exp_q    [32][$];
    int          hold_node  [MAX_CMDS];
    int          hold_start [MAX_CMDS];
    int          hold_len   [MAX_CMDS];
    int          num_holds;
    int          hold_total;
    int          inj_cnt [4][2];
    int          ret_cnt [4][2];
    int          cur_src [4][2];
    logic        in_pkt  [4][2];
    int          gap     [4];
    logic        held    [4];
    flit_t       held_flit [4];
    int          total_flits;
    int          delivered;
    int          returned;
    int          cycle;
    int          limit;
    int          errors;
    int          checks;
    logic        go;

    switch_wrapper #(
        .BUFFER_SIZE(BUFFER_SIZE)
    ) switch_wrapper_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .in_flit         (in_flit),
        .data_ready_in   (data_ready_in),
        .packet_sent     (packet_sent),
        .out             (out),
        .data_ready_out  (data_ready_out),
        .buffer_available(buffer_available)
    );

    always #10 clk = ~clk;

    task automatic flag_mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("Fail %s: got 0x%h expected 0x%h", name, got, want);
        errors++;
    endtask

    task automatic note_problem(string msg);
        $display("%s", msg);
        errors++;
    endtask

    function automatic logic node_held(int node, int cyc);
        for (int h = 0; h < num_holds; h++) begin
            if (hold_node[h] == node && cyc >= hold_start[h] &&
                cyc < hold_start[h] + hold_len[h]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Expands packet commands into flits and collects hold windows
    task automatic load_stimulus();
        flit_t       f;
        logic [63:0] cmd;
        int          src;
        int          dst;
        int          len;
        logic        done;
        done = 1'b0;
        for (int i = 0; i < MAX_CMDS; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("tb/noc_stim.txt", stim_mem);
        for (int i = 0; i < MAX_CMDS && !done; i++) begin
            cmd = stim_mem[i];
            case (cmd[63:60])
                4'h1: begin
                    src = int'(cmd[57:56]);
                    dst = int'(cmd[49:48]);
                    len = int'(cmd[39:32]);
                    for (int k = 0; k < len; k++) begin
                        f = '0;
                        f.vc   = cmd[52];
                        f.head = (k == 0);
                        f.last = (k == len - 1);
                        if (k == 0) begin
                            f.data.hdr.dest   = cmd[49:48];
                            f.data.hdr.src    = cmd[57:56];
                            f.data.hdr.pkt_id = cmd[47:40];
                        end else begin
                            f.data.body = cmd[28:0] + 29'(k);
                        end
                        inj_q[src].push_back(f);
                        exp_q[dst * 8 + src * 2 + int'(cmd[52])].push_back(f);
                        total_flits++;
                    end
                end
                4'h2: begin
                    hold_node[num_holds]  = int'(cmd[57:56]);
                    hold_start[num_holds] = int'(cmd[31:16]);
                    hold_len[num_holds]   = int'(cmd[15:0]);
                    hold_total += int'(cmd[15:0]);
                    num_holds++;
                end
                default: done = 1'b1;
            endcase
        end
    endtask

    always @(posedge clk) begin : drive_inputs
        flit_t f;
        if (go) begin
            for (int n = 0; n < 4; n++) begin
                packet_sent[n]   <= !node_held(n, cycle);
                data_ready_in[n] <= 1'b0;
                if (gap[n] > 0) begin
                    gap[n]--;
                end else if (inj_q[n].size() > 0) begin
                    f = inj_q[n][0];
                    // Endpoint may only send while it holds a credit for this VC
                    if (inj_cnt[n][f.vc] - ret_cnt[n][f.vc] < BUFFER_SIZE) begin
                        in_flit[n]       <= f;
                        data_ready_in[n] <= 1'b1;
                        void'(inj_q[n].pop_front());
                        inj_cnt[n][f.vc]++;
                        gap[n] = int'($urandom % 3);
                    end
                end
            end
            cycle++;
        end
    end

    // Outputs are sampled mid-cycle and a transfer happens at the next rising edge
    always @(negedge clk) begin : check_outputs
        flit_t got;
        flit_t want;
        int    src;
        int    key;
        for (int n = 0; n < 4; n++) begin
            if (held[n]) begin
                checks++;
                if (!data_ready_out[n]) begin
                    note_problem($sformatf("Node %0d dropped its output while it was held", n));
                end else if (out[n] !== held_flit[n]) begin
                    flag_mismatch($sformatf("out[%0d] while held", n), out[n], held_flit[n]);
                end
            end
            held[n]      = data_ready_out[n] && !packet_sent[n];
            held_flit[n] = out[n];
            if (!go && arst_n && data_ready_out[n]) begin
                note_problem($sformatf("Node %0d raised data_ready_out with no traffic", n));
            end
            if (go && data_ready_out[n] && packet_sent[n]) begin
                got = out[n];
                checks++;
                if (got.head) begin
                    if (in_pkt[n][got.vc]) begin
                        note_problem($sformatf("Head flit cut into an open packet at node %0d vc %0d",
                                               n, got.vc));
                    end
                    src = int'(got.data.hdr.src);
                    cur_src[n][got.vc] = src;
                    in_pkt[n][got.vc]  = !got.last;
                end else begin
                    if (!in_pkt[n][got.vc]) begin
                        note_problem($sformatf("Body flit without a head at node %0d vc %0d",
                                               n, got.vc));
                    end
                    src = cur_src[n][got.vc];
                    if (got.last) begin
                        in_pkt[n][got.vc] = 1'b0;
                    end
                end
                key = n * 8 + src * 2 + int'(got.vc);
                if (exp_q[key].size() == 0) begin
                    note_problem($sformatf("Unexpected flit 0x%h arrived at node %0d", got, n));
                end else begin
                    want = exp_q[key].pop_front();
                    if (got !== want) begin
                        flag_mismatch($sformatf("out[%0d]", n), got, want);
                    end
                end
                delivered++;
            end
        end
        for (int n = 0; n < 4; n++) begin
            for (int v = 0; v < 2; v++) begin
                if (buffer_available[n + 4 * v]) begin
                    if (!go && arst_n) begin
                        note_problem($sformatf("Credit pulse at node %0d vc %0d with no traffic",
                                               n, v));
                    end
                    ret_cnt[n][v]++;
                    returned++;
                    if (ret_cnt[n][v] > inj_cnt[n][v]) begin
                        note_problem($sformatf("Node %0d vc %0d returned more credits than flits",
                                               n, v));
                    end
                end
            end
        end
    end

    initial begin : watchdog
        wait (go);
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, %0d of %0d flits delivered",
                 limit, delivered, total_flits);
        $display("Test failures found");
        $finish;
    end

    initial begin : main
        void'($urandom(46951));
        clk    = 1'b0;
        arst_n = 1'b0;
        go     = 1'b0;
        for (int n = 0; n < 4; n++) begin
            in_flit[n]       = '0;
            data_ready_in[n] = 1'b0;
            packet_sent[n]   = 1'b1;
            held[n]          = 1'b0;
            gap[n]           = 0;
            for (int v = 0; v < 2; v++) begin
                in_pkt[n][v] = 1'b0;
            end
        end
        load_stimulus();
        limit = 60 * total_flits + hold_total + 200;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        // Quiet window where outputs must stay low
        repeat (5) @(posedge clk);
        go <= 1'b1;
        while (delivered < total_flits || returned < total_flits) begin
            @(posedge clk);
        end
        @(negedge clk);
        for (int k = 0; k < 32; k++) begin
            if (exp_q[k].size() != 0) begin
                note_problem($sformatf("%0d flits from node %0d vc %0d never reached node %0d",
                                       exp_q[k].size(), (k % 8) / 2, k % 2, k / 8));
            end
        end
        for (int n = 0; n < 4; n++) begin
            for (int v = 0; v < 2; v++) begin
                checks++;
                if (ret_cnt[n][v] != inj_cnt[n][v]) begin
                    flag_mismatch($sformatf("buffer_available[%0d] count", n + 4 * v),
                                  ret_cnt[n][v], inj_cnt[n][v]);
                end
            end
        end
        $display("Checks: %0d, errors: %0d, flits delivered: %0d of %0d",
                 checks, errors, delivered, total_flits);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* hw/switch_wrapper.sv */
`timescale 1ns/1ps

module switch_wrapper import noc_pkg::*; #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic  clk,
    input  logic  arst_n,
    // Injection side
    input  flit_t in_flit          [4],
    input  logic  data_ready_in    [4],
    input  logic  packet_sent      [4],
    // Ejection side
    output flit_t out              [4],
    output logic  data_ready_out   [4],
    output logic  buffer_available [8]
);
    localparam int NUM_NODES = 4;

    // Mesh layout with node id x + 2*y
    //
    //   0 --X-- 1
    //   |       |
    //   Y       Y
    //   |       |
    //   2 --X-- 3

    flit_t sw_in_flit    [NUM_NODES][NUM_PORTS];
    logic  sw_in_valid   [NUM_NODES][NUM_PORTS];
    logic  sw_credit_in  [NUM_NODES][NUM_PORTS][NUM_VCS];
    flit_t sw_out_flit   [NUM_NODES][NUM_PORTS];
    logic  sw_out_valid  [NUM_NODES][NUM_PORTS];
    logic  sw_credit_out [NUM_NODES][NUM_PORTS][NUM_VCS];

    for (genvar n = 0; n < NUM_NODES; n++) begin : g_node
        // Horizontal partner differs in bit 0 and vertical partner in bit 1
        localparam int NX = n ^ 1;
        localparam int NY = n ^ 2;

        assign sw_in_flit[n][PORT_LOCAL]  = in_flit[n];
        assign sw_in_valid[n][PORT_LOCAL] = data_ready_in[n];
        assign sw_in_flit[n][PORT_X]      = sw_out_flit[NX][PORT_X];
        assign sw_in_valid[n][PORT_X]     = sw_out_valid[NX][PORT_X];
        assign sw_in_flit[n][PORT_Y]      = sw_out_flit[NY][PORT_Y];
        assign sw_in_valid[n][PORT_Y]     = sw_out_valid[NY][PORT_Y];

        for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
            // Ejection is paced by packet_sent, not by credits
            assign sw_credit_in[n][PORT_LOCAL][v] = 1'b0;
            assign sw_credit_in[n][PORT_X][v]     = sw_credit_out[NX][PORT_X][v];
            assign sw_credit_in[n][PORT_Y][v]     = sw_credit_out[NY][PORT_Y][v];
            assign buffer_available[n + NUM_NODES * v] = sw_credit_out[n][PORT_LOCAL][v];
        end

        assign out[n]            = sw_out_flit[n][PORT_LOCAL];
        assign data_ready_out[n] = sw_out_valid[n][PORT_LOCAL];

        switch #(
            .NODE       (n),
            .BUFFER_SIZE(BUFFER_SIZE)
        ) u_switch (
            .clk         (clk),
            .arst_n      (arst_n),
            .in_flit     (sw_in_flit[n]),
            .in_valid    (sw_in_valid[n]),
            .credit_in   (sw_credit_in[n]),
            .eject_accept(packet_sent[n]),
            .out_flit    (sw_out_flit[n]),
            .out_valid   (sw_out_valid[n]),
            .credit_out  (sw_credit_out[n])
        );
    end

endmodule

/* switch/switch.sv */
`timescale 1ns/1ps

module switch import noc_pkg::*; #(
    parameter int NODE        = 0,
    parameter int BUFFER_SIZE = 8
) (
    input  logic  clk,
    input  logic  arst_n,
    input  flit_t in_flit      [NUM_PORTS],
    input  logic  in_valid     [NUM_PORTS],
    input  logic  credit_in    [NUM_PORTS][NUM_VCS],
    input  logic  eject_accept,
    output flit_t out_flit     [NUM_PORTS],
    output logic  out_valid    [NUM_PORTS],
    output logic  credit_out   [NUM_PORTS][NUM_VCS]
);
    flit_t      buf_flit   [NUM_PORTS][NUM_VCS];
    logic       buf_valid  [NUM_PORTS][NUM_VCS];
    logic [1:0] req_port   [NUM_PORTS][NUM_VCS];
    logic       grant      [NUM_PORTS][NUM_VCS];
    flit_t      xbar_flit  [NUM_PORTS];
    logic       xbar_valid [NUM_PORTS];
    logic       local_busy;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        vc_buffer #(
            .BUFFER_SIZE(BUFFER_SIZE)
        ) u_vc_buffer (
            .clk          (clk),
            .arst_n       (arst_n),
            .wr_flit      (in_flit[p]),
            .wr_valid     (in_valid[p]),
            .pop          (grant[p]),
            .head_flit    (buf_flit[p]),
            .not_empty    (buf_valid[p]),
            .credit_return(credit_out[p])
        );

        for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
            route_unit #(
                .NODE(NODE)
            ) u_route_unit (
                .clk      (clk),
                .arst_n   (arst_n),
                .head_flit(buf_flit[p][v]),
                .not_empty(buf_valid[p][v]),
                .pop      (grant[p][v]),
                .out_port (req_port[p][v])
            );
        end
    end

    // Endpoint still holds a flit it has not taken
    assign local_busy = out_valid[PORT_LOCAL] && !eject_accept;

    switch_allocator #(
        .BUFFER_SIZE(BUFFER_SIZE)
    ) u_switch_allocator (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_port  (req_port),
        .req_valid (buf_valid),
        .req_flit  (buf_flit),
        .credit_in (credit_in),
        .local_busy(local_busy),
        .grant     (grant)
    );

    // Crossbar with at most one grant reaching each output
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            xbar_valid[o] = 1'b0;
            xbar_flit[o]  = '0;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                if (grant[p][v]) begin
                    xbar_valid[req_port[p][v]] = 1'b1;
                    xbar_flit[req_port[p][v]]  = buf_flit[p][v];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (xbar_valid[o]) begin
                out_flit[o] <= xbar_flit[o];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                out_valid[o] <= 1'b0;
            end
        end else begin
            // Mesh links strobe once per flit
            for (int o = 1; o < NUM_PORTS; o++) begin
                out_valid[o] <= xbar_valid[o];
            end
            // Ejection holds until the endpoint accepts
            if (xbar_valid[PORT_LOCAL]) begin
                out_valid[PORT_LOCAL] <= 1'b1;
            end else if (eject_accept) begin
                out_valid[PORT_LOCAL] <= 1'b0;
            end
        end
    end

endmodule

/* switch/switch_allocator.sv */
`timescale 1ns/1ps

module switch_allocator import noc_pkg::*; #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic [1:0] req_port   [NUM_PORTS][NUM_VCS],
    input  logic       req_valid  [NUM_PORTS][NUM_VCS],
    input  flit_t      req_flit   [NUM_PORTS][NUM_VCS],
    input  logic       credit_in  [NUM_PORTS][NUM_VCS],
    input  logic       local_busy,
    output logic       grant      [NUM_PORTS][NUM_VCS]
);
    localparam int NUM_REQ = NUM_PORTS * NUM_VCS;
    localparam int REQ_W   = $clog2(NUM_REQ);
    localparam int CRED_W  = $clog2(BUFFER_SIZE + 1);

    // Output VC ownership
    // Input VC equals output VC so only the port is kept
    logic              lock_valid [NUM_PORTS][NUM_VCS];
    logic [1:0]        lock_owner [NUM_PORTS][NUM_VCS];
    // Credits only exist for the mesh outputs
    logic [CRED_W-1:0] credits    [1:NUM_PORTS-1][NUM_VCS];
    logic [REQ_W-1:0]  rr_ptr     [NUM_PORTS];
    logic              eligible   [NUM_PORTS][NUM_VCS];
    logic              win_valid  [NUM_PORTS];
    logic [REQ_W-1:0]  win_idx    [NUM_PORTS];
    logic              vc_sent    [NUM_PORTS][NUM_VCS];

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                eligible[p][v] = req_valid[p][v];
                if (req_valid[p][v]) begin
                    if (lock_valid[req_port[p][v]][v]) begin
                        if (lock_owner[req_port[p][v]][v] != 2'(p)) begin
                            eligible[p][v] = 1'b0;
                        end
                    end else if (!req_flit[p][v].head) begin
                        eligible[p][v] = 1'b0;
                    end
                    if (req_port[p][v] == 2'(PORT_LOCAL)) begin
                        if (local_busy) begin
                            eligible[p][v] = 1'b0;
                        end
                    end else if (credits[req_port[p][v]][v] == '0) begin
                        eligible[p][v] = 1'b0;
                    end
                end
            end
        end
    end

    // Round robin per output
    // The candidate nearest after the pointer wins
    always_comb begin
        int idx;
        for (int o = 0; o < NUM_PORTS; o++) begin
            win_valid[o] = 1'b0;
            win_idx[o]   = '0;
            for (int k = NUM_REQ - 1; k >= 0; k--) begin
                idx = (int'(rr_ptr[o]) + k) % NUM_REQ;
                if (eligible[idx / NUM_VCS][idx % NUM_VCS] &&
                    req_port[idx / NUM_VCS][idx % NUM_VCS] == 2'(o)) begin
                    win_valid[o] = 1'b1;
                    win_idx[o]   = REQ_W'(idx);
                end
            end
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                grant[p][v] = 1'b0;
            end
        end
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                vc_sent[o][v] = win_valid[o] && (int'(win_idx[o]) % NUM_VCS == v);
            end
            if (win_valid[o]) begin
                grant[win_idx[o] / NUM_VCS][win_idx[o] % NUM_VCS] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                rr_ptr[o] <= '0;
                for (int v = 0; v < NUM_VCS; v++) begin
                    lock_valid[o][v] <= 1'b0;
                    lock_owner[o][v] <= '0;
                end
            end
            for (int o = 1; o < NUM_PORTS; o++) begin
                for (int v = 0; v < NUM_VCS; v++) begin
                    credits[o][v] <= CRED_W'(BUFFER_SIZE);
                end
            end
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (win_valid[o]) begin
                    rr_ptr[o] <= (win_idx[o] == REQ_W'(NUM_REQ - 1)) ? '0 : win_idx[o] + 1'b1;
                    if (req_flit[win_idx[o] / NUM_VCS][win_idx[o] % NUM_VCS].last) begin
                        lock_valid[o][win_idx[o] % NUM_VCS] <= 1'b0;
                    end else if (req_flit[win_idx[o] / NUM_VCS][win_idx[o] % NUM_VCS].head) begin
                        lock_valid[o][win_idx[o] % NUM_VCS] <= 1'b1;
                        lock_owner[o][win_idx[o] % NUM_VCS] <= 2'(win_idx[o] / NUM_VCS);
                    end
                end
            end
            for (int o = 1; o < NUM_PORTS; o++) begin
                for (int v = 0; v < NUM_VCS; v++) begin
                    if (vc_sent[o][v] && !credit_in[o][v]) begin
                        credits[o][v] <= credits[o][v] - 1'b1;
                    end else if (!vc_sent[o][v] && credit_in[o][v]) begin
                        credits[o][v] <= credits[o][v] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* switch/route_unit.sv */
`timescale 1ns/1ps

module route_unit import noc_pkg::*; #(
    parameter int NODE = 0
) (
    input  logic       clk,
    input  logic       arst_n,
    input  flit_t      head_flit,
    input  logic       not_empty,
    input  logic       pop,
    output logic [1:0] out_port
);
    localparam logic [NODE_W-1:0] SELF = NODE_W'(NODE);

    logic [NODE_W-1:0] dest;
    logic [1:0]        xy_port;
    logic [1:0]        held_port;

    assign dest = head_flit.data.hdr.dest;

    // X first, then Y, then eject
    always_comb begin
        if (node_x(dest) != node_x(SELF)) begin
            xy_port = 2'(PORT_X);
        end else if (node_y(dest) != node_y(SELF)) begin
            xy_port = 2'(PORT_Y);
        end else begin
            xy_port = 2'(PORT_LOCAL);
        end
    end

    // Body flits carry no destination and reuse the head's port
    assign out_port = head_flit.head ? xy_port : held_port;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held_port <= 2'(PORT_LOCAL);
        end else if (pop && not_empty) begin
            if (head_flit.last) begin
                held_port <= 2'(PORT_LOCAL);
            end else if (head_flit.head) begin
                held_port <= xy_port;
            end
        end
    end

endmodule

/* switch/vc_buffer.sv */
`timescale 1ns/1ps

module vc_buffer import noc_pkg::*; #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic  clk,
    input  logic  arst_n,
    input  flit_t wr_flit,
    input  logic  wr_valid,
    input  logic  pop           [NUM_VCS],
    output flit_t head_flit     [NUM_VCS],
    output logic  not_empty     [NUM_VCS],
    output logic  credit_return [NUM_VCS]
);
    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    flit_t            mem    [NUM_VCS][BUFFER_SIZE];
    logic [PTR_W-1:0] wr_ptr [NUM_VCS];
    logic [PTR_W-1:0] rd_ptr [NUM_VCS];
    logic [CNT_W-1:0] count  [NUM_VCS];
    logic             fresh  [NUM_VCS];
    logic             push   [NUM_VCS];
    logic             take   [NUM_VCS];

    always_comb begin
        for (int v = 0; v < NUM_VCS; v++) begin
            push[v] = wr_valid && (wr_flit.vc == 1'(v));
            take[v] = pop[v] && not_empty[v];
            head_flit[v] = mem[v][rd_ptr[v]];
            // A flit written at the last edge is not offered until the next cycle
            not_empty[v] = count[v] > CNT_W'(fresh[v]);
        end
    end

    always_ff @(posedge clk) begin
        for (int v = 0; v < NUM_VCS; v++) begin
            if (push[v]) begin
                mem[v][wr_ptr[v]] <= wr_flit;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                wr_ptr[v]        <= '0;
                rd_ptr[v]        <= '0;
                count[v]         <= '0;
                fresh[v]         <= 1'b0;
                credit_return[v] <= 1'b0;
            end
        end else begin
            for (int v = 0; v < NUM_VCS; v++) begin
                if (push[v]) begin
                    wr_ptr[v] <= (wr_ptr[v] == PTR_W'(BUFFER_SIZE - 1)) ? '0 : wr_ptr[v] + 1'b1;
                end
                if (take[v]) begin
                    rd_ptr[v] <= (rd_ptr[v] == PTR_W'(BUFFER_SIZE - 1)) ? '0 : rd_ptr[v] + 1'b1;
                end
                if (push[v] && !take[v]) begin
                    count[v] <= count[v] + 1'b1;
                end else if (!push[v] && take[v]) begin
                    count[v] <= count[v] - 1'b1;
                end
                fresh[v] <= push[v];
                // One credit back upstream per flit leaving the buffer
                credit_return[v] <= take[v];
            end
        end
    end

endmodule

/* common/noc_pkg.sv */
package noc_pkg;

    // Switch geometry is fixed because the flit format and mesh wiring rely on it
    localparam int NUM_PORTS = 3;
    localparam int NUM_VCS   = 2;
    localparam int NODE_W    = 2;

    // Same port order at every node
    localparam int PORT_LOCAL = 0;
    localparam int PORT_X     = 1;
    localparam int PORT_Y     = 2;

    // Routing fields carried by a head flit
    typedef struct packed {
        logic [NODE_W-1:0] dest;
        logic [NODE_W-1:0] src;
        logic [7:0]        pkt_id;
        logic [16:0]       spare;
    } head_view_t;

    // Payload is read as routing info on a head flit and as raw data otherwise
    typedef union packed {
        head_view_t  hdr;
        logic [28:0] body;
    } flit_data_u;

    // A single-flit packet has both head and last set
    typedef struct packed {
        logic       vc;
        logic       head;
        logic       last;
        flit_data_u data;
    } flit_t;

    // Node id is x + 2*y
    function automatic logic node_x(input logic [NODE_W-1:0] id);
        return id[0];
    endfunction

    function automatic logic node_y(input logic [NODE_W-1:0] id);
        return id[1];
    endfunction

endpackage
